// File: hw/vec_pkg.sv
/*
  Shared sizes and types of the vector unit. Elements are 32 bits only.
  A host vl must not exceed NrLanes * VrfDepth, and NrLanes must not exceed MaxLanes.
*/
package vec_pkg;

  // Register file geometry
  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned VrfDepth  = 8;
  localparam int unsigned RowWidth  = $clog2(VrfDepth);

  // Instruction ids that may be in flight at once
  localparam int unsigned NrVInsn  = 4;
  localparam int unsigned MaxLanes = 8;

  // Operand queues per lane, one per ALU source
  localparam int unsigned NrOperandQueues = 2;

  typedef logic [$clog2(MaxLanes * VrfDepth + 1)-1:0] vl_t;
  typedef logic [$clog2(NrVInsn)-1:0]                 vid_t;
  typedef logic [$clog2(NrVRegs)-1:0]                 vreg_t;
  // Lane-local word address, register index above row
  typedef logic [$clog2(NrVRegs * VrfDepth)-1:0]      vaddr_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL
  } opcode_e;

  // Queue A carries vs1, queue B carries vs2
  typedef enum logic {
    OPQ_A = 1'b0,
    OPQ_B = 1'b1
  } opqueue_e;

  // Host instruction
  typedef struct packed {
    opcode_e opcode;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    vl_t     vl;
    vl_t     vstart;
  } vec_req_t;

  // Broadcast to the lanes
  typedef struct packed {
    vid_t               id;
    opcode_e            opcode;
    vreg_t              vd;
    vreg_t              vs1;
    vreg_t              vs2;
    vl_t                vl;
    vl_t                vstart;
    logic [NrVInsn-1:0] hazard_vs1;
    logic [NrVInsn-1:0] hazard_vs2;
    // Live set of running ids, used to clear hazards
    logic [NrVInsn-1:0] vinsn_running;
  } pe_req_t;

  // Operand queue entry, vl and vstart are lane-local rows
  typedef struct packed {
    vid_t               id;
    vreg_t              vs;
    vl_t                vl;
    vl_t                vstart;
    logic [NrVInsn-1:0] hazard;
  } operand_cmd_t;

  // Lane ALU operation
  typedef struct packed {
    vid_t    id;
    opcode_e opcode;
    vreg_t   vd;
    vl_t     vl;
    vl_t     vstart;
  } lane_op_t;

endpackage

// File: hw/vec_main_sequencer.sv
/*
  Accepts one host instruction at a time and broadcasts it to all lanes.
  Only read-after-write hazards are tracked. One id retires per cycle at most.
*/
`timescale 1ns/1ps

module vec_main_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  vec_pkg::vec_req_t                              req_i,
  input  logic                                           req_valid_i,
  output logic                                           req_ready_o,
  output vec_pkg::pe_req_t                               pe_req_o,
  output logic                                           pe_req_valid_o,
  input  logic [NrLanes-1:0]                             lane_ready_i,
  input  logic [NrLanes-1:0][vec_pkg::NrVInsn-1:0]       lane_done_i,
  output logic                                           done_o,
  output vec_pkg::vid_t                                  done_id_o,
  output logic                                           busy_o
);
  import vec_pkg::*;

  logic [NrVInsn-1:0]              running_q, running_d;
  vreg_t [NrVInsn-1:0]             vd_q;
  // Lanes that reported done, per id
  logic [NrVInsn-1:0][NrLanes-1:0] finished_q, finished_d;
  pe_req_t                         pe_req_q;
  logic                            pe_req_valid_q, pe_req_valid_d;
  logic                            free_valid, retire_valid, accept;
  vid_t                            free_id, retire_id;
  logic [NrVInsn-1:0]              hazard_vs1, hazard_vs2;

  always_comb begin : p_select
    free_valid   = 1'b0;
    free_id      = '0;
    retire_valid = 1'b0;
    retire_id    = '0;
    // Walk down so the lowest index wins
    for (int k = NrVInsn - 1; k >= 0; k--) begin
      if (!running_q[k]) begin
        free_valid = 1'b1;
        free_id    = vid_t'(k);
      end
      if (running_q[k] && (&finished_q[k])) begin
        retire_valid = 1'b1;
        retire_id    = vid_t'(k);
      end
      // RAW check against every running producer
      hazard_vs1[k] = running_q[k] && (vd_q[k] == req_i.vs1);
      hazard_vs2[k] = running_q[k] && (vd_q[k] == req_i.vs2);
    end
  end

  // No new instruction while a broadcast is still pending
  assign req_ready_o = free_valid && !pe_req_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin : p_track
    running_d      = running_q;
    pe_req_valid_d = pe_req_valid_q;
    for (int k = 0; k < NrVInsn; k++) begin
      for (int l = 0; l < NrLanes; l++) begin
        finished_d[k][l] = finished_q[k][l] | lane_done_i[l][k];
      end
    end
    if (retire_valid) begin
      running_d[retire_id]  = 1'b0;
      finished_d[retire_id] = '0;
    end
    // Every lane ready in the same cycle ends the broadcast
    if (pe_req_valid_q && (&lane_ready_i)) begin
      pe_req_valid_d = 1'b0;
    end
    if (accept) begin
      running_d[free_id] = 1'b1;
      pe_req_valid_d     = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      finished_q     <= '0;
      vd_q           <= '0;
      pe_req_q       <= '0;
      pe_req_valid_q <= 1'b0;
    end else begin
      running_q      <= running_d;
      finished_q     <= finished_d;
      pe_req_valid_q <= pe_req_valid_d;
      if (accept) begin
        vd_q[free_id] <= req_i.vd;
        pe_req_q      <= '{id: free_id, opcode: req_i.opcode, vd: req_i.vd, vs1: req_i.vs1,
                           vs2: req_i.vs2, vl: req_i.vl, vstart: req_i.vstart,
                           hazard_vs1: hazard_vs1, hazard_vs2: hazard_vs2,
                           vinsn_running: running_q};
      end
    end
  end

  // Lanes see the running set as it is now, not as it was at acceptance
  always_comb begin
    pe_req_o               = pe_req_q;
    pe_req_o.vinsn_running = running_q;
  end

  assign pe_req_valid_o = pe_req_valid_q;
  assign done_o         = retire_valid;
  assign done_id_o      = retire_id;
  assign busy_o         = (|running_q) || pe_req_valid_q;

endmodule

// File: hw/lane_sequencer.sv
/*
  Sequencer of one lane. Operand queues hold one entry each and their hazard
  bits are cleared live from the broadcast running set. A lane that already
  took a broadcast id stays ready so the other lanes can catch up.
*/
`timescale 1ns/1ps

module lane_sequencer #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned LaneId  = 0
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  vec_pkg::pe_req_t                                      pe_req_i,
  input  logic                                                  pe_req_valid_i,
  output logic                                                  pe_req_ready_o,
  output vec_pkg::operand_cmd_t [vec_pkg::NrOperandQueues-1:0]  operand_cmd_o,
  output logic [vec_pkg::NrOperandQueues-1:0]                   operand_cmd_valid_o,
  input  logic [vec_pkg::NrOperandQueues-1:0]                   operand_cmd_ready_i,
  output vec_pkg::lane_op_t                                     lane_op_o,
  output logic                                                  lane_op_valid_o,
  input  logic                                                  alu_ready_i,
  input  logic [vec_pkg::NrVInsn-1:0]                           alu_vinsn_done_i,
  output logic [vec_pkg::NrVInsn-1:0]                           vinsn_done_o
);
  import vec_pkg::*;

  operand_cmd_t [NrOperandQueues-1:0] cmd_new, cmd_d;
  logic [NrOperandQueues-1:0]         cmd_push, cmd_valid_d;
  lane_op_t                           lane_op_d;
  logic                               lane_op_valid_d;
  logic [NrVInsn-1:0]                 running_q, running_d;
  vl_t                                lane_vl, lane_vstart;

  // Element e sits in lane e mod NrLanes, so this lane gets one extra row
  // when its index is below the remainder
  always_comb begin : p_split
    lane_vl     = vl_t'(pe_req_i.vl / NrLanes);
    lane_vstart = vl_t'(pe_req_i.vstart / NrLanes);
    if (LaneId < pe_req_i.vl % NrLanes) begin
      lane_vl = lane_vl + vl_t'(1);
    end
    if (LaneId < pe_req_i.vstart % NrLanes) begin
      lane_vstart = lane_vstart + vl_t'(1);
    end
  end

  always_comb begin : p_queues
    for (int q = 0; q < NrOperandQueues; q++) begin
      cmd_d[q]       = operand_cmd_o[q];
      cmd_valid_d[q] = operand_cmd_valid_o[q];
      // Requester took the entry
      if (operand_cmd_ready_i[q]) begin
        cmd_d[q]       = '0;
        cmd_valid_d[q] = 1'b0;
      end
      if (cmd_push[q]) begin
        cmd_d[q]       = cmd_new[q];
        cmd_valid_d[q] = 1'b1;
      end
      // Producers that retired no longer block
      cmd_d[q].hazard = cmd_d[q].hazard & pe_req_i.vinsn_running;
    end
  end

  always_comb begin : p_sequencer
    running_d       = running_q & pe_req_i.vinsn_running;
    pe_req_ready_o  = 1'b1;
    cmd_new         = '0;
    cmd_push        = '0;
    lane_op_d       = '0;
    lane_op_valid_d = 1'b0;

    if (lane_op_valid_o && !alu_ready_i) begin
      // ALU still busy, hold the operation
      lane_op_d       = lane_op_o;
      lane_op_valid_d = 1'b1;
      pe_req_ready_o  = 1'b0;
    end else if (pe_req_valid_i && !running_q[pe_req_i.id]) begin
      lane_op_d = '{id: pe_req_i.id, opcode: pe_req_i.opcode, vd: pe_req_i.vd,
                    vl: lane_vl, vstart: lane_vstart};
      lane_op_valid_d         = 1'b1;
      running_d[pe_req_i.id]  = 1'b1;

      cmd_new[OPQ_A] = '{id: pe_req_i.id, vs: pe_req_i.vs1, vl: lane_vl,
                         vstart: lane_vstart, hazard: pe_req_i.hazard_vs1};
      cmd_new[OPQ_B] = '{id: pe_req_i.id, vs: pe_req_i.vs2, vl: lane_vl,
                         vstart: lane_vstart, hazard: pe_req_i.hazard_vs2};
      cmd_push       = '1;

      // A queue is still occupied, retry next cycle
      if (|(cmd_push & operand_cmd_valid_o)) begin
        cmd_push               = '0;
        lane_op_valid_d        = 1'b0;
        running_d[pe_req_i.id] = 1'b0;
        pe_req_ready_o         = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_cmd_o       <= '0;
      operand_cmd_valid_o <= '0;
      lane_op_o           <= '0;
      lane_op_valid_o     <= 1'b0;
      running_q           <= '0;
      vinsn_done_o        <= '0;
    end else begin
      operand_cmd_o       <= cmd_d;
      operand_cmd_valid_o <= cmd_valid_d;
      lane_op_o           <= lane_op_d;
      lane_op_valid_o     <= lane_op_valid_d;
      running_q           <= running_d;
      vinsn_done_o        <= alu_vinsn_done_i;
    end
  end

endmodule

// File: hw/operand_requester.sv
/*
  Streams the source rows of each operand queue out of the register slice.
  A command is taken only once its hazard mask is clear, so there is no chaining.
*/
`timescale 1ns/1ps

module operand_requester (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  vec_pkg::operand_cmd_t [vec_pkg::NrOperandQueues-1:0]       cmd_i,
  input  logic [vec_pkg::NrOperandQueues-1:0]                        cmd_valid_i,
  output logic [vec_pkg::NrOperandQueues-1:0]                        cmd_ready_o,
  output vec_pkg::vaddr_t [vec_pkg::NrOperandQueues-1:0]             vrf_raddr_o,
  input  logic [vec_pkg::NrOperandQueues-1:0][vec_pkg::ElemWidth-1:0] vrf_rdata_i,
  output logic [vec_pkg::NrOperandQueues-1:0][vec_pkg::ElemWidth-1:0] opnd_o,
  output logic [vec_pkg::NrOperandQueues-1:0]                        opnd_valid_o,
  input  logic [vec_pkg::NrOperandQueues-1:0]                        opnd_ready_i
);
  import vec_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_HAZARD,
    STREAM
  } state_e;

  for (genvar q = 0; q < NrOperandQueues; q++) begin : gen_queue
    state_e               state_q, state_d;
    operand_cmd_t         cmd_q;
    vl_t                  row_q;
    logic                 take, issue, pop;
    // Read data arrives one cycle after the address
    logic                 rd_pending_q;
    logic                 skid_valid_q, skid_valid_d;
    logic [ElemWidth-1:0] skid_q;

    // Skid entry is older than the data coming back from the slice
    assign opnd_valid_o[q] = skid_valid_q || rd_pending_q;
    assign opnd_o[q]       = skid_valid_q ? skid_q : vrf_rdata_i[q];
    assign pop             = opnd_valid_o[q] && opnd_ready_i[q];
    assign skid_valid_d    = (skid_valid_q && !pop) || (rd_pending_q && (skid_valid_q || !pop));

    assign take           = (state_q != STREAM) && cmd_valid_i[q] && (cmd_i[q].hazard == '0);
    assign cmd_ready_o[q] = take;
    // Read only when the skid buffer can absorb a stall
    assign issue          = (state_q == STREAM) && (row_q < cmd_q.vl) && !skid_valid_d;
    assign vrf_raddr_o[q] = {cmd_q.vs, row_q[RowWidth-1:0]};

    always_comb begin
      state_d = state_q;
      unique case (state_q)
        IDLE:        if (cmd_valid_i[q]) state_d = take ? STREAM : WAIT_HAZARD;
        WAIT_HAZARD: if (take) state_d = STREAM;
        STREAM:      if (row_q >= cmd_q.vl) state_d = IDLE;
        default:     state_d = IDLE;
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q      <= IDLE;
        cmd_q        <= '0;
        row_q        <= '0;
        rd_pending_q <= 1'b0;
        skid_valid_q <= 1'b0;
        skid_q       <= '0;
      end else begin
        state_q      <= state_d;
        rd_pending_q <= issue;
        skid_valid_q <= skid_valid_d;
        if (take) begin
          cmd_q <= cmd_i[q];
          row_q <= cmd_i[q].vstart;
        end else if (issue) begin
          row_q <= row_q + vl_t'(1);
        end
        if (rd_pending_q && (skid_valid_q || !pop)) begin
          skid_q <= vrf_rdata_i[q];
        end
      end
    end
  end

endmodule

// File: hw/lane_alu.sv
/*
  Lane ALU, one operation at a time. Result is A op B with A from vs1 and B from vs2,
  so sub gives vs1 - vs2 and shift-left shifts vs1 by the low 5 bits of vs2.
*/
`timescale 1ns/1ps

module lane_alu (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  vec_pkg::lane_op_t                                          op_i,
  input  logic                                                       op_valid_i,
  output logic                                                       alu_ready_o,
  input  logic [vec_pkg::NrOperandQueues-1:0][vec_pkg::ElemWidth-1:0] opnd_i,
  input  logic [vec_pkg::NrOperandQueues-1:0]                        opnd_valid_i,
  output logic [vec_pkg::NrOperandQueues-1:0]                        opnd_ready_o,
  output logic                                                       vrf_we_o,
  output vec_pkg::vaddr_t                                            vrf_waddr_o,
  output logic [vec_pkg::ElemWidth-1:0]                              vrf_wdata_o,
  output logic [vec_pkg::NrVInsn-1:0]                                vinsn_done_o
);
  import vec_pkg::*;

  lane_op_t             op_q;
  logic                 busy_q;
  vl_t                  row_q;
  logic                 take, empty, fire, last;
  logic [ElemWidth-1:0] a, b, result;

  assign alu_ready_o = !busy_q;
  assign take        = op_valid_i && !busy_q;
  // Nothing to do in this lane, or every row already processed
  assign empty       = busy_q && (row_q >= op_q.vl);
  // Both operand streams must be valid together
  assign fire        = busy_q && !empty && (&opnd_valid_i);
  assign last        = fire && ((row_q + vl_t'(1)) >= op_q.vl);

  assign a = opnd_i[OPQ_A];
  assign b = opnd_i[OPQ_B];

  always_comb begin
    unique case (op_q.opcode)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      OP_SLL:  result = a << b[4:0];
      default: result = '0;
    endcase
  end

  assign opnd_ready_o = {NrOperandQueues{fire}};
  assign vrf_we_o     = fire;
  assign vrf_waddr_o  = {op_q.vd, row_q[RowWidth-1:0]};
  assign vrf_wdata_o  = result;
  // Done on the last write, or the cycle after taking an empty op
  assign vinsn_done_o = (last || empty) ? (NrVInsn'(1) << op_q.id) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q   <= '0;
      busy_q <= 1'b0;
      row_q  <= '0;
    end else if (take) begin
      op_q   <= op_i;
      busy_q <= 1'b1;
      row_q  <= op_i.vstart;
    end else if (fire) begin
      row_q <= row_q + vl_t'(1);
      if (last) begin
        busy_q <= 1'b0;
      end
    end else if (empty) begin
      busy_q <= 1'b0;
    end
  end

endmodule

// File: hw/lane_vrf.sv
/*
  Register slice of one lane, NrVRegs by VrfDepth words, cleared at reset.
  All reads are registered. The host writes only while the unit is idle.
*/
`timescale 1ns/1ps

module lane_vrf (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  vec_pkg::vaddr_t [vec_pkg::NrOperandQueues-1:0]             raddr_i,
  output logic [vec_pkg::NrOperandQueues-1:0][vec_pkg::ElemWidth-1:0] rdata_o,
  input  logic                                                       alu_we_i,
  input  vec_pkg::vaddr_t                                            alu_waddr_i,
  input  logic [vec_pkg::ElemWidth-1:0]                              alu_wdata_i,
  input  logic                                                       host_we_i,
  input  vec_pkg::vaddr_t                                            host_addr_i,
  input  logic [vec_pkg::ElemWidth-1:0]                              host_wdata_i,
  output logic [vec_pkg::ElemWidth-1:0]                              host_rdata_o
);
  import vec_pkg::*;

  logic [ElemWidth-1:0] mem_q [NrVRegs * VrfDepth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrVRegs * VrfDepth; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o      <= '0;
      host_rdata_o <= '0;
    end else begin
      // ALU write wins
      if (alu_we_i) begin
        mem_q[alu_waddr_i] <= alu_wdata_i;
      end else if (host_we_i) begin
        mem_q[host_addr_i] <= host_wdata_i;
      end
      for (int p = 0; p < NrOperandQueues; p++) begin
        rdata_o[p] <= mem_q[raddr_i[p]];
      end
      host_rdata_o <= mem_q[host_addr_i];
    end
  end

endmodule

// File: hw/vec_top.sv
/*
  Vector unit top with NrLanes lanes, NrLanes at most MaxLanes.
  Element port is for use while busy_o is low; read data follows elem_re_i by one cycle.
*/
`timescale 1ns/1ps

module vec_top #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  vec_pkg::vec_req_t             req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  output logic                          done_o,
  output vec_pkg::vid_t                 done_id_o,
  output logic                          busy_o,
  input  logic                          elem_we_i,
  input  logic                          elem_re_i,
  input  vec_pkg::vreg_t                elem_vreg_i,
  input  vec_pkg::vl_t                  elem_idx_i,
  input  logic [vec_pkg::ElemWidth-1:0] elem_wdata_i,
  output logic [vec_pkg::ElemWidth-1:0] elem_rdata_o
);
  import vec_pkg::*;

  localparam int unsigned LaneIdxW = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  pe_req_t                         pe_req;
  logic                            pe_req_valid;
  logic [NrLanes-1:0]              pe_req_ready;
  logic [NrLanes-1:0][NrVInsn-1:0] lane_done;
  logic [NrLanes-1:0][ElemWidth-1:0] host_rdata;
  logic [LaneIdxW-1:0]             elem_lane, rd_lane_q;
  vaddr_t                          elem_addr;

  vec_main_sequencer #(.NrLanes(NrLanes)) u_main_sequencer (
    .clk_i, .rst_ni, .req_i, .req_valid_i, .req_ready_o,
    .pe_req_o       (pe_req),
    .pe_req_valid_o (pe_req_valid),
    .lane_ready_i   (pe_req_ready),
    .lane_done_i    (lane_done),
    .done_o, .done_id_o, .busy_o
  );

  // Element index to lane and row
  assign elem_lane = LaneIdxW'(elem_idx_i % NrLanes);
  assign elem_addr = {elem_vreg_i, RowWidth'(elem_idx_i / NrLanes)};

  // Remember which lane a read targets
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_lane_q <= '0;
    end else if (elem_re_i) begin
      rd_lane_q <= elem_lane;
    end
  end

  assign elem_rdata_o = host_rdata[rd_lane_q];

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    operand_cmd_t [NrOperandQueues-1:0]         opnd_cmd;
    logic [NrOperandQueues-1:0]                 opnd_cmd_valid, opnd_cmd_ready;
    lane_op_t                                   lane_op;
    logic                                       lane_op_valid, alu_ready;
    logic [NrVInsn-1:0]                         alu_done;
    vaddr_t [NrOperandQueues-1:0]               raddr;
    logic [NrOperandQueues-1:0][ElemWidth-1:0]  rdata, opnd;
    logic [NrOperandQueues-1:0]                 opnd_valid, opnd_ready;
    logic                                       vrf_we;
    vaddr_t                                     vrf_waddr;
    logic [ElemWidth-1:0]                       vrf_wdata;

    lane_sequencer #(.NrLanes(NrLanes), .LaneId(l)) u_lane_sequencer (
      .clk_i, .rst_ni,
      .pe_req_i            (pe_req),
      .pe_req_valid_i      (pe_req_valid),
      .pe_req_ready_o      (pe_req_ready[l]),
      .operand_cmd_o       (opnd_cmd),
      .operand_cmd_valid_o (opnd_cmd_valid),
      .operand_cmd_ready_i (opnd_cmd_ready),
      .lane_op_o           (lane_op),
      .lane_op_valid_o     (lane_op_valid),
      .alu_ready_i         (alu_ready),
      .alu_vinsn_done_i    (alu_done),
      .vinsn_done_o        (lane_done[l])
    );

    operand_requester u_operand_requester (
      .clk_i, .rst_ni,
      .cmd_i        (opnd_cmd),
      .cmd_valid_i  (opnd_cmd_valid),
      .cmd_ready_o  (opnd_cmd_ready),
      .vrf_raddr_o  (raddr),
      .vrf_rdata_i  (rdata),
      .opnd_o       (opnd),
      .opnd_valid_o (opnd_valid),
      .opnd_ready_i (opnd_ready)
    );

    lane_alu u_lane_alu (
      .clk_i, .rst_ni,
      .op_i         (lane_op),
      .op_valid_i   (lane_op_valid),
      .alu_ready_o  (alu_ready),
      .opnd_i       (opnd),
      .opnd_valid_i (opnd_valid),
      .opnd_ready_o (opnd_ready),
      .vrf_we_o     (vrf_we),
      .vrf_waddr_o  (vrf_waddr),
      .vrf_wdata_o  (vrf_wdata),
      .vinsn_done_o (alu_done)
    );

    lane_vrf u_lane_vrf (
      .clk_i, .rst_ni,
      .raddr_i      (raddr),
      .rdata_o      (rdata),
      .alu_we_i     (vrf_we),
      .alu_waddr_i  (vrf_waddr),
      .alu_wdata_i  (vrf_wdata),
      .host_we_i    (elem_we_i && (elem_lane == LaneIdxW'(l))),
      .host_addr_i  (elem_addr),
      .host_wdata_i (elem_wdata_i),
      .host_rdata_o (host_rdata[l])
    );
  end

endmodule

// File: dv/tb_vec_top.sv
/*
  Testbench of vec_top with 4 lanes, random stimulus from an xorshift generator (seed 44).
  Element reads and writes happen only while busy_o is low. vl stays within NrLanes * VrfDepth.
  The first failing check ends the run.
*/
`timescale 1ns/1ps

module tb_vec_top;
  import vec_pkg::*;

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned NrElems   = NrLanes * VrfDepth;
  localparam int unsigned NrOps     = 6;
  // Six instructions per opcode
  localparam int unsigned NumSingle = 6 * NrOps;
  localparam int unsigned NumStart  = 12;
  localparam int unsigned NumChain  = 24;
  localparam int unsigned InsnBound = 200;
  // Two cycles per element access
  localparam int unsigned SweepCycles    = 2 * NrVRegs * NrElems;
  localparam int unsigned VdCheckCycles  = 2 * NrElems;
  localparam int unsigned WatchdogCycles = (NumSingle + NumStart + NumChain) * InsnBound
                                         + (NumSingle + NumStart) * VdCheckCycles
                                         + 6 * SweepCycles + 100;

  logic                 clk_i;
  logic                 rst_ni;
  vec_req_t             req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  logic                 done_o;
  vid_t                 done_id_o;
  logic                 busy_o;
  logic                 elem_we_i;
  logic                 elem_re_i;
  vreg_t                elem_vreg_i;
  vl_t                  elem_idx_i;
  logic [ElemWidth-1:0] elem_wdata_i;
  logic [ElemWidth-1:0] elem_rdata_o;

  // Expected contents of every vector register
  logic [ElemWidth-1:0] model_q [NrVRegs][NrElems];
  // Ids the unit holds, as predicted from the lowest-free rule
  logic [NrVInsn-1:0]   in_flight;
  logic [31:0]          rng_state;

  vec_top #(.NrLanes(NrLanes)) u_vec_top (
    .clk_i, .rst_ni, .req_i, .req_valid_i, .req_ready_o,
    .done_o, .done_id_o, .busy_o,
    .elem_we_i, .elem_re_i, .elem_vreg_i, .elem_idx_i, .elem_wdata_i, .elem_rdata_o
  );

  always #10 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Result is vs1 op vs2, shift amount from the low 5 bits of vs2
  function automatic logic [ElemWidth-1:0] alu_ref(input opcode_e op,
                                                   input logic [ElemWidth-1:0] a,
                                                   input logic [ElemWidth-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      default: return '0;
    endcase
  endfunction

  // Only elements from vstart up to vl change
  task automatic apply_model(input vec_req_t r);
    for (int e = int'(r.vstart); e < int'(r.vl); e++) begin
      model_q[r.vd][e] = alu_ref(r.opcode, model_q[r.vs1][e], model_q[r.vs2][e]);
    end
  endtask

  function automatic vec_req_t rand_req(input opcode_e op, input bit nonzero_start);
    vec_req_t    r;
    int unsigned start;
    r.opcode = op;
    r.vd     = vreg_t'(next_rand());
    r.vs1    = vreg_t'(next_rand());
    r.vs2    = vreg_t'(next_rand());
    r.vl     = vl_t'(next_rand() % (NrElems + 1));
    r.vstart = '0;
    if (nonzero_start) begin
      start    = 1 + (next_rand() % (NrElems - 1));
      r.vstart = vl_t'(start);
      r.vl     = vl_t'(start + (next_rand() % (NrElems - start + 1)));
    end
    return r;
  endfunction

  task automatic write_elem(input int unsigned v, input int unsigned idx,
                            input logic [ElemWidth-1:0] data);
    @(negedge clk_i);
    elem_we_i    = 1'b1;
    elem_vreg_i  = vreg_t'(v);
    elem_idx_i   = vl_t'(idx);
    elem_wdata_i = data;
    @(negedge clk_i);
    elem_we_i    = 1'b0;
    model_q[v][idx] = data;
  endtask

  // Read data is valid one cycle after elem_re_i
  task automatic check_elem(input int unsigned v, input int unsigned idx);
    @(negedge clk_i);
    elem_re_i   = 1'b1;
    elem_vreg_i = vreg_t'(v);
    elem_idx_i  = vl_t'(idx);
    @(negedge clk_i);
    elem_re_i   = 1'b0;
    assert (elem_rdata_o == model_q[v][idx])
    else report_failure($sformatf("CHECK FAILED elem_rdata_o v%0d[%0d]: got %h expected %h",
                                  v, idx, elem_rdata_o, model_q[v][idx]));
  endtask

  task automatic check_vreg(input int unsigned v);
    for (int unsigned idx = 0; idx < NrElems; idx++) begin
      check_elem(v, idx);
    end
  endtask

  task automatic check_all();
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      check_vreg(v);
    end
  endtask

  // Holds valid until ready, then predicts the id the unit assigns
  task automatic issue_insn(input vec_req_t r);
    int unsigned waited;
    int unsigned id;
    logic        found;
    @(negedge clk_i);
    req_i       = r;
    req_valid_i = 1'b1;
    waited      = 0;
    while (!req_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > InsnBound) begin
        report_failure("Instruction was not accepted in time");
      end
    end
    // An id retiring this cycle is still taken at the coming edge
    found = 1'b0;
    id    = 0;
    for (int k = NrVInsn - 1; k >= 0; k--) begin
      if (!in_flight[k] && !(done_o && (done_id_o == vid_t'(k)))) begin
        found = 1'b1;
        id    = k;
      end
    end
    assert (found)
    else report_failure("Unit accepted an instruction while every id was in flight");
    in_flight[id] = 1'b1;
    apply_model(r);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned waited;
    waited = 0;
    while (busy_o || (in_flight != '0)) begin
      @(negedge clk_i);
      waited++;
      if (waited > InsnBound * NrVInsn) begin
        report_failure("Unit did not go idle in time");
      end
    end
  endtask

  // Every done must match an id in flight, once
  always @(negedge clk_i) begin
    if (rst_ni && done_o) begin
      assert (in_flight[done_id_o])
      else report_failure($sformatf("CHECK FAILED done_id_o: got %h, in flight mask %h",
                                    done_id_o, in_flight));
      in_flight[done_id_o] = 1'b0;
    end
  end

  initial begin : watchdog
    #(WatchdogCycles * 20);
    report_failure("Watchdog expired, the run took too long");
  end

  initial begin : stimulus
    vec_req_t r;
    vreg_t    prev_vd;
    opcode_e  op;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    elem_we_i    = 1'b0;
    elem_re_i    = 1'b0;
    elem_vreg_i  = '0;
    elem_idx_i   = '0;
    elem_wdata_i = '0;
    rng_state    = 32'd44;
    in_flight    = '0;
    prev_vd      = '0;
    for (int v = 0; v < NrVRegs; v++) begin
      for (int e = 0; e < NrElems; e++) begin
        model_q[v][e] = '0;
      end
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle state after reset, register file cleared
    @(negedge clk_i);
    assert (req_ready_o == 1'b1)
    else report_failure($sformatf("CHECK FAILED req_ready_o: got %h expected 1", req_ready_o));
    assert (busy_o == 1'b0)
    else report_failure($sformatf("CHECK FAILED busy_o: got %h expected 0", busy_o));
    assert (done_o == 1'b0)
    else report_failure($sformatf("CHECK FAILED done_o: got %h expected 0", done_o));
    check_all();

    // Fill every element, then read all back for lane and row routing
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      for (int unsigned e = 0; e < NrElems; e++) begin
        write_elem(v, e, next_rand());
      end
    end
    check_all();

    // Single instructions, first round with vl 0, second with vl off the lane grid
    for (int unsigned i = 0; i < NumSingle; i++) begin
      op = opcode_e'(i % NrOps);
      r  = rand_req(op, 1'b0);
      if (i / NrOps == 0) begin
        r.vl = '0;
      end else if (i / NrOps == 1) begin
        r.vl = vl_t'(NrElems - 1 - (next_rand() % 3));
      end
      issue_insn(r);
      wait_idle();
      check_vreg(r.vd);
    end
    check_all();

    // Nonzero vstart, lower elements of vd keep their value
    for (int unsigned i = 0; i < NumStart; i++) begin
      op = opcode_e'(next_rand() % NrOps);
      r  = rand_req(op, 1'b1);
      issue_insn(r);
      wait_idle();
      check_vreg(r.vd);
    end
    check_all();

    // Dependent chain issued without waiting
    for (int unsigned i = 0; i < NumChain; i++) begin
      op = opcode_e'(next_rand() % NrOps);
      r  = rand_req(op, next_rand() % 2 == 0);
      if (i > 0) begin
        if (next_rand() % 2 == 0) begin
          r.vs1 = prev_vd;
        end else begin
          r.vs2 = prev_vd;
        end
      end
      issue_insn(r);
      prev_vd = r.vd;
    end
    wait_idle();
    check_all();

    $display("Test passed");
    $finish;
  end

endmodule

// File: vlog.f
hw/vec_pkg.sv
hw/vec_main_sequencer.sv
hw/lane_sequencer.sv
hw/operand_requester.sv
hw/lane_alu.sv
hw/lane_vrf.sv
hw/vec_top.sv
dv/tb_vec_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the vector unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_vec_top -f vlog.f -o sim_tb_vec_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_vec_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
